// File: project.f
+incdir+source
source/cpuPkg.sv
source/instDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/sequenceCtrl.sv
source/datapathTop.sv
testbench/datapathChecker.sv
testbench/datapathTb.sv

// File: source/aluUnit.sv
`include "cpu_macros.svh"

module aluUnit (
	input  logic                        CLK,
	input  logic                        rstN,
	input  cpuPkg::aluOpT               aluOp,
	input  logic                        flagUpdate,
	input  logic [`CPU_DATA_WIDTH-1:0]  opA,
	input  logic [`CPU_DATA_WIDTH-1:0]  opB,
	output logic [`CPU_DATA_WIDTH-1:0]  result,
	output cpuPkg::flagsT               flags
);
	import cpuPkg::*;

	logic [`CPU_DATA_WIDTH:0]   sumWide;
	logic [`CPU_DATA_WIDTH:0]   diffWide;
	logic [3:0]                 shiftAmt;
	logic [`CPU_DATA_WIDTH-1:0] shifted;
	flagsT                      nextFlags;

	//////////////////////////////////////////////////////////////////////
	// arithmetic
	//////////////////////////////////////////////////////////////////////

	// one extra bit for carry and borrow
	assign sumWide  = {1'b0, opA} + {1'b0, opB};
	assign diffWide = {1'b0, opA} - {1'b0, opB};

	// negative opB shifts right by its magnitude
	assign shiftAmt = opB[`CPU_DATA_WIDTH-1] ? (4'd0 - opB[3:0]) : opB[3:0];
	assign shifted  = opB[`CPU_DATA_WIDTH-1] ? (opA >> shiftAmt) : (opA << shiftAmt);

	//////////////////////////////////////////////////////////////////////
	// result and next flags
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		result = opA;
		// untouched flags keep their value
		nextFlags = flags;

		case (aluOp)
			ALU_ADD: begin
				result             = sumWide[`CPU_DATA_WIDTH-1:0];
				nextFlags.carry    = sumWide[`CPU_DATA_WIDTH];
				// same input signs, different result sign
				nextFlags.overflow = (opA[`CPU_DATA_WIDTH-1] == opB[`CPU_DATA_WIDTH-1]) &&
					(sumWide[`CPU_DATA_WIDTH-1] != opA[`CPU_DATA_WIDTH-1]);
			end
			ALU_SUB: begin
				result             = diffWide[`CPU_DATA_WIDTH-1:0];
				// carry holds the borrow
				nextFlags.carry    = diffWide[`CPU_DATA_WIDTH];
				nextFlags.overflow = (opA[`CPU_DATA_WIDTH-1] != opB[`CPU_DATA_WIDTH-1]) &&
					(diffWide[`CPU_DATA_WIDTH-1] != opA[`CPU_DATA_WIDTH-1]);
			end
			ALU_CMP: begin
				// difference is visible on aluOut only
				result             = diffWide[`CPU_DATA_WIDTH-1:0];
				nextFlags.low      = (opB < opA);
				nextFlags.zero     = (opA == opB);
				nextFlags.negative = ($signed(opB) < $signed(opA));
			end
			ALU_AND, ALU_OR, ALU_XOR, ALU_LSH: begin
				case (aluOp)
					ALU_AND: result = opA & opB;
					ALU_OR:  result = opA | opB;
					ALU_XOR: result = opA ^ opB;
					default: result = shifted;
				endcase
				// logic ops touch Z and N only
				nextFlags.zero     = (result == '0);
				nextFlags.negative = result[`CPU_DATA_WIDTH-1];
			end
			ALU_MOV: result = opB;
			// pass opA through for mem ops
			default: result = opA;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// flag register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagUpdate) begin
			flags <= nextFlags;
		end
	end

endmodule

// File: source/cpuPkg.sv
`include "cpu_macros.svh"

package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////////////////////////

	// primary opcode in bits 15:12
	typedef enum logic [3:0] {
		OP_RTYPE = 4'b0000,
		OP_ANDI  = 4'b0001,
		OP_ORI   = 4'b0010,
		OP_XORI  = 4'b0011,
		OP_MEM   = 4'b0100,
		OP_ADDI  = 4'b0101,
		OP_SUBI  = 4'b1001,
		OP_CMPI  = 4'b1011,
		OP_MOVI  = 4'b1101
	} opcodeT;

	// secondary code in bits 7:4, shared by register and MEM groups
	typedef enum logic [3:0] {
		EXT_LOAD  = 4'b0000,
		EXT_AND   = 4'b0001,
		EXT_OR    = 4'b0010,
		EXT_XOR   = 4'b0011,
		EXT_STOR  = 4'b0100,
		EXT_ADD   = 4'b0101,
		EXT_LSH   = 4'b1000,
		EXT_SUB   = 4'b1001,
		EXT_CMP   = 4'b1011,
		EXT_JCOND = 4'b1100,
		EXT_MOV   = 4'b1101
	} extT;

	// jump condition sits in the rDest field of a JCOND
	typedef enum logic [3:0] {
		COND_BEQ  = 4'b0000,
		COND_BNEQ = 4'b0001,
		COND_BLT  = 4'b1100,
		COND_BGE  = 4'b1101,
		COND_JUC  = 4'b1110
	} condT;

	// register view: opcode rDest ext rSrc
	typedef struct packed {
		opcodeT                        opcode;
		logic [`CPU_REG_IDX_WIDTH-1:0] rDest;
		extT                           ext;
		logic [`CPU_REG_IDX_WIDTH-1:0] rSrc;
	} instRegT;

	// immediate view: opcode rDest imm8
	typedef struct packed {
		opcodeT                        opcode;
		logic [`CPU_REG_IDX_WIDTH-1:0] rDest;
		logic [7:0]                    imm8;
	} instImmT;

	// one instruction word, two decodings
	typedef union packed {
		instRegT regView;
		instImmT immView;
	} instT;

	//////////////////////////////////////////////////////////////////////
	// internal control
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_CMP, ALU_AND,
		ALU_OR, ALU_XOR, ALU_MOV, ALU_LSH
	} aluOpT;

	// C L F Z N, carry in the msb
	typedef struct packed {
		logic carry;
		logic low;
		logic overflow;
		logic zero;
		logic negative;
	} flagsT;

	typedef struct packed {
		aluOpT aluOp;
		logic  selImm;    // operand B from imm
		logic  selLoad;   // write back external data
		logic  regWrite;
		logic  setFlags;
		logic  memLoad;
		logic  memStore;
		logic  jump;
		condT  cond;
	} ctrlT;

endpackage

// File: source/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// width of registers, ALU operands and memory words
`define CPU_DATA_WIDTH 16

// sixteen general registers
`define CPU_REG_COUNT 16

// register select width
`define CPU_REG_IDX_WIDTH 4

// memory operations finish in the last phase of the counter
`define CPU_STALL_PHASE 2'd3

`endif

// File: source/datapathTop.sv
`include "cpu_macros.svh"

module datapathTop (
	input  logic                        CLK,
	input  logic                        rstN,
	input  cpuPkg::instT                inst,
	input  logic [`CPU_DATA_WIDTH-1:0]  externalDin,
	output logic                        memWrite,
	output logic [`CPU_DATA_WIDTH-1:0]  memAddr,
	output logic [`CPU_DATA_WIDTH-1:0]  storeData,
	output logic [`CPU_DATA_WIDTH-1:0]  aluOut,
	output cpuPkg::flagsT               flags,
	output logic                        pcInc,
	output logic                        jAddrSelect
);
	import cpuPkg::*;

	ctrlT                          ctrl;
	logic [`CPU_REG_IDX_WIDTH-1:0] readA;
	logic [`CPU_REG_IDX_WIDTH-1:0] readB;
	logic [`CPU_REG_IDX_WIDTH-1:0] writeSel;
	logic [`CPU_DATA_WIDTH-1:0]    imm;
	logic [`CPU_DATA_WIDTH-1:0]    regA;
	logic [`CPU_DATA_WIDTH-1:0]    regB;
	logic [`CPU_DATA_WIDTH-1:0]    opB;
	logic [`CPU_DATA_WIDTH-1:0]    writeData;
	logic                          commit;
	logic                          regWriteEn;
	logic                          flagUpdate;

	//////////////////////////////////////////////////////////////////////
	// decode and register read
	//////////////////////////////////////////////////////////////////////

	instDecoder decoder (.inst, .ctrl, .readA, .readB, .writeSel, .imm);

	// nothing is written until the instruction commits
	assign regWriteEn = ctrl.regWrite & commit;

	regFile regs (
		.CLK, .rstN,
		.writeEn (regWriteEn),
		.writeSel, .writeData,
		.readA, .readB,
		.regA, .regB
	);

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	// sign extended imm or second register
	assign opB = ctrl.selImm ? imm : regB;

	assign flagUpdate = ctrl.setFlags & commit;

	aluUnit alu (
		.CLK, .rstN,
		.aluOp (ctrl.aluOp),
		.flagUpdate,
		.opA (regA), .opB,
		.result (aluOut),
		.flags
	);

	// load takes memory data, else alu result
	assign writeData = ctrl.selLoad ? externalDin : aluOut;

	//////////////////////////////////////////////////////////////////////
	// sequencing and memory side
	//////////////////////////////////////////////////////////////////////

	sequenceCtrl sequencer (.CLK, .rstN, .ctrl, .flags, .pcInc, .jAddrSelect, .commit);

	// regA is also the jump target
	assign memAddr   = regA;
	assign storeData = regB;
	assign memWrite  = ctrl.memStore;

endmodule

// File: source/instDecoder.sv
`include "cpu_macros.svh"

module instDecoder (
	input  cpuPkg::instT                   inst,
	output cpuPkg::ctrlT                   ctrl,
	output logic [`CPU_REG_IDX_WIDTH-1:0]  readA,
	output logic [`CPU_REG_IDX_WIDTH-1:0]  readB,
	output logic [`CPU_REG_IDX_WIDTH-1:0]  writeSel,
	output logic [`CPU_DATA_WIDTH-1:0]     imm
);
	import cpuPkg::*;

	logic isMem;

	// opcode is in the same place in both views
	assign isMem = (inst.regView.opcode == OP_MEM);

	//////////////////////////////////////////////////////////////////////
	// register selects
	//////////////////////////////////////////////////////////////////////

	// alu ops read rDest and rSrc
	// mem ops address from rSrc, store data from rDest
	assign readA    = isMem ? inst.regView.rSrc : inst.regView.rDest;
	assign readB    = isMem ? inst.regView.rDest : inst.regView.rSrc;
	assign writeSel = inst.regView.rDest;

	// sign extend imm8 to full width
	assign imm = {{(`CPU_DATA_WIDTH-8){inst.immView.imm8[7]}}, inst.immView.imm8};

	//////////////////////////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// default is a nop
		ctrl = '0;
		ctrl.aluOp = ALU_PASS;
		// cond only matters for jcond
		ctrl.cond = condT'(inst.regView.rDest);

		case (inst.regView.opcode)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.setFlags = 1'b1;
				case (inst.regView.ext)
					EXT_ADD: ctrl.aluOp = ALU_ADD;
					EXT_SUB: ctrl.aluOp = ALU_SUB;
					EXT_AND: ctrl.aluOp = ALU_AND;
					EXT_OR:  ctrl.aluOp = ALU_OR;
					EXT_XOR: ctrl.aluOp = ALU_XOR;
					EXT_LSH: ctrl.aluOp = ALU_LSH;
					EXT_CMP: begin
						// flags only, rDest untouched
						ctrl.aluOp    = ALU_CMP;
						ctrl.regWrite = 1'b0;
					end
					EXT_MOV: begin
						ctrl.aluOp    = ALU_MOV;
						ctrl.setFlags = 1'b0;
					end
					default: begin
						ctrl.regWrite = 1'b0;
						ctrl.setFlags = 1'b0;
					end
				endcase
			end
			OP_ADDI, OP_SUBI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI, OP_MOVI: begin
				// immediate group, operand B from imm
				ctrl.selImm   = 1'b1;
				ctrl.regWrite = (inst.immView.opcode != OP_CMPI);
				ctrl.setFlags = (inst.immView.opcode != OP_MOVI);
				case (inst.immView.opcode)
					OP_ADDI: ctrl.aluOp = ALU_ADD;
					OP_SUBI: ctrl.aluOp = ALU_SUB;
					OP_CMPI: ctrl.aluOp = ALU_CMP;
					OP_ANDI: ctrl.aluOp = ALU_AND;
					OP_ORI:  ctrl.aluOp = ALU_OR;
					OP_XORI: ctrl.aluOp = ALU_XOR;
					default: ctrl.aluOp = ALU_MOV;
				endcase
			end
			OP_MEM: begin
				case (inst.regView.ext)
					EXT_LOAD: begin
						ctrl.memLoad  = 1'b1;
						ctrl.selLoad  = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					EXT_STOR:  ctrl.memStore = 1'b1;
					EXT_JCOND: ctrl.jump     = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: source/regFile.sv
`include "cpu_macros.svh"

module regFile (
	input  logic                           CLK,
	input  logic                           rstN,
	input  logic                           writeEn,
	input  logic [`CPU_REG_IDX_WIDTH-1:0]  writeSel,
	input  logic [`CPU_DATA_WIDTH-1:0]     writeData,
	input  logic [`CPU_REG_IDX_WIDTH-1:0]  readA,
	input  logic [`CPU_REG_IDX_WIDTH-1:0]  readB,
	output logic [`CPU_DATA_WIDTH-1:0]     regA,
	output logic [`CPU_DATA_WIDTH-1:0]     regB
);

	//////////////////////////////////////////////////////////////////////
	// register array
	//////////////////////////////////////////////////////////////////////

	logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

	// all registers read zero after reset
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			// single write port
			regs[writeSel] <= writeData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////////////////////////

	// combinational, a write shows up next cycle
	assign regA = regs[readA];
	assign regB = regs[readB];

endmodule

// File: source/sequenceCtrl.sv
`include "cpu_macros.svh"

module sequenceCtrl (
	input  logic          CLK,
	input  logic          rstN,
	input  cpuPkg::ctrlT  ctrl,
	input  cpuPkg::flagsT flags,
	output logic          pcInc,
	output logic          jAddrSelect,
	output logic          commit
);
	import cpuPkg::*;

	logic [1:0] phase;
	logic       memOp;
	logic       condMet;

	//////////////////////////////////////////////////////////////////////
	// phase counter
	//////////////////////////////////////////////////////////////////////

	// free running 0 1 2 3 0, not restarted per instruction
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stall
	//////////////////////////////////////////////////////////////////////

	// load and store wait for the last phase
	assign memOp = ctrl.memLoad | ctrl.memStore;

	// everything else, jumps too, completes at once
	assign commit = !memOp || (phase == `CPU_STALL_PHASE);

	// fetch side advances when the instruction completes
	assign pcInc = commit;

	//////////////////////////////////////////////////////////////////////
	// jump condition
	//////////////////////////////////////////////////////////////////////

	// flags come from the last committed compare
	always_comb begin
		case (ctrl.cond)
			COND_JUC:  condMet = 1'b1;
			COND_BEQ:  condMet = flags.zero;
			COND_BNEQ: condMet = !flags.zero;
			COND_BLT:  condMet = flags.negative;
			COND_BGE:  condMet = !flags.negative;
			// unused encodings never jump
			default:   condMet = 1'b0;
		endcase
	end

	// selects the target from memAddr instead of pc + 1
	assign jAddrSelect = ctrl.jump && condMet;

endmodule

// File: testbench/datapathChecker.sv
module datapathChecker (
	input  logic          CLK,
	input  logic          check,
	input  logic [7:0]    testId,
	input  int            lineNo,
	input  logic [55:0]   expected,
	input  logic [15:0]   aluOut,
	input  cpuPkg::flagsT flags,
	input  logic [15:0]   memAddr,
	input  logic [15:0]   storeData,
	input  logic          memWrite,
	input  logic          pcInc,
	input  logic          jAddrSelect,
	output int            errorCount
);
	import cpuPkg::*;

	// expected port values of one golden line
	typedef struct packed {
		logic [15:0] aluOut;
		flagsT       flags;
		logic [15:0] memAddr;
		logic [15:0] storeData;
		logic        memWrite;
		logic        pcInc;
		logic        jAddrSelect;
	} expectT;

	expectT want;

	assign want = expected;

	// golden ids map onto the test groups
	function automatic string testName(input logic [7:0] id);
		case (id)
			8'd1:    return "arith";
			8'd2:    return "jump";
			8'd3:    return "load";
			8'd4:    return "store";
			8'd5:    return "logic";
			8'd6:    return "reset";
			default: return "unknown";
		endcase
	endfunction

	task automatic compareField(input string field, input logic [15:0] expVal,
		input logic [15:0] actVal);
		if (actVal !== expVal) begin
			errorCount++;
			$display("[FAIL] test %s, line %0d, %s: expected %h actual %h",
				testName(testId), lineNo, field, expVal, actVal);
		end
	endtask

	initial errorCount = 0;

	//////////////////////////////////////////////////////////////////////
	// compare mid cycle, outputs settle after the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge CLK) begin
		if (check) begin
			compareField("aluOut", want.aluOut, aluOut);
			// flags are the registered value before this instruction
			compareField("flags", 16'(want.flags), 16'(flags));
			compareField("memAddr", want.memAddr, memAddr);
			compareField("storeData", want.storeData, storeData);
			compareField("memWrite", 16'(want.memWrite), 16'(memWrite));
			compareField("pcInc", 16'(want.pcInc), 16'(pcInc));
			compareField("jAddrSelect", 16'(want.jAddrSelect), 16'(jAddrSelect));
		end
	end

endmodule

// File: testbench/datapathTb.sv
module datapathTb;
	import cpuPkg::*;

	localparam int MaxLines    = 64;
	localparam int Fields      = 10;
	localparam int ResetCycles = 16;
	localparam int ClockPeriod = 8;

	logic        CLK;
	logic        rstN;
	instT        inst;
	logic [15:0] externalDin;
	logic        memWrite;
	logic [15:0] memAddr;
	logic [15:0] storeData;
	logic [15:0] aluOut;
	flagsT       flags;
	logic        pcInc;
	logic        jAddrSelect;

	// checker side
	logic        check;
	logic [7:0]  testId;
	int          lineNo;
	logic [55:0] expected;
	int          errorCount;

	// ten words per golden line
	logic [15:0] golden [0:MaxLines*Fields-1];
	int          lineCount;
	logic        loaded;

	always #(ClockPeriod/2) CLK = ~CLK;

	datapathTop dut (
		.CLK, .rstN, .inst, .externalDin,
		.memWrite, .memAddr, .storeData, .aluOut, .flags, .pcInc, .jAddrSelect
	);

	datapathChecker monitor (
		.CLK, .check, .testId, .lineNo, .expected,
		.aluOut, .flags, .memAddr, .storeData, .memWrite, .pcInc, .jAddrSelect,
		.errorCount
	);

	// unused entries hold the inverted entry index
	function automatic logic [15:0] fillWord(input int addr);
		return ~addr[15:0];
	endfunction

	// lines end where the id word still holds its fill value
	function automatic int countLines();
		int n;
		n = 0;
		while (n < MaxLines && golden[n*Fields] !== fillWord(n*Fields)) begin
			n++;
		end
		return n;
	endfunction

	// drive one golden line on the current rising edge
	task automatic applyLine(input int idx);
		int base;
		base = idx * Fields;
		testId      <= golden[base][7:0];
		inst        <= golden[base+1];
		externalDin <= golden[base+2];
		expected    <= {golden[base+3], golden[base+4][4:0], golden[base+5], golden[base+6],
			golden[base+7][0], golden[base+8][0], golden[base+9][0]};
		lineNo      <= idx;
		check       <= 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		CLK         = 1'b0;
		rstN        = 1'b0;
		inst        = '0;
		externalDin = '0;
		check       = 1'b0;
		testId      = '0;
		lineNo      = 0;
		expected    = '0;
		loaded      = 1'b0;
		for (int i = 0; i < MaxLines*Fields; i++) begin
			golden[i] = fillWord(i);
		end
		$readmemh("testbench/datapath_golden.txt", golden);
		lineCount = countLines();
		loaded    = 1'b1;
		if (lineCount == 0) begin
			$display("no stimulus lines could be read from the golden file");
		end else begin
			repeat (ResetCycles) @(posedge CLK);
			// line 0 starts with the phase counter at 0
			rstN <= 1'b1;
			applyLine(0);
			for (int i = 1; i < lineCount; i++) begin
				@(posedge CLK);
				applyLine(i);
			end
			@(posedge CLK);
			check <= 1'b0;
		end
		@(negedge CLK);
		$display("%0d lines checked, %0d errors", lineCount, errorCount);
		if (errorCount == 0 && lineCount > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// run length is reset plus one cycle per line plus slack
	initial begin
		wait (loaded);
		#((lineCount + ResetCycles + 10) * ClockPeriod);
		$display("watchdog expired, the stimulus never finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: testbench/datapath_golden.txt
// id inst din aluOut flags memAddr storeData memWrite pcInc jAddrSelect
// one line per cycle from reset release, phase is line mod 4, flags {C,L,F,Z,N}
// reset: registers and flags read zero
06 01D2 0000 0000 00 0000 0000 0 1 0
06 0FDE 0000 0000 00 0000 0000 0 1 0
// arith: movi, lsh setup, add overflow, add carry, sub borrow, subi
01 D17F 0000 007F 00 0000 0000 0 1 0
01 D208 0000 0008 00 0000 0000 0 1 0
01 0182 0000 7F00 00 007F 0008 0 1 0
01 0151 0000 FE00 00 7F00 7F00 0 1 0
01 0151 0000 FC00 04 FE00 FE00 0 1 0
01 0291 0000 0408 10 0008 FC00 0 1 0
01 9208 0000 0400 10 0408 0000 0 1 0
01 03D2 0000 0400 00 0000 0400 0 1 0
// jump: cmp then beq bneq blt bge juc
02 02B3 0000 0000 00 0400 0400 0 1 0
02 40C1 0000 FC00 02 FC00 0000 0 1 1
02 41C1 0000 FC00 02 FC00 FC00 0 1 0
02 01B2 0000 F800 02 FC00 0400 0 1 0
02 4CC3 0000 0400 08 0400 0000 0 1 0
02 4DC3 0000 0400 08 0400 0000 0 1 1
02 02B1 0000 0800 08 0400 FC00 0 1 0
02 4CC3 0000 0400 01 0400 0000 0 1 1
02 4EC1 0000 FC00 01 FC00 0000 0 1 1
// load: one in phase 3, one stalled from phase 0, then mov out
03 4402 BEEF 0400 01 0400 0000 0 1 0
03 4502 DEAD 0400 01 0400 0000 0 0 0
03 4502 DEAD 0400 01 0400 0000 0 0 0
03 4502 DEAD 0400 01 0400 0000 0 0 0
03 4502 1234 0400 01 0400 0000 0 1 0
03 06D5 0000 1234 01 0000 1234 0 1 0
03 07D4 0000 BEEF 01 0000 BEEF 0 1 0
// store: from phase 2, then from phase 0
04 4543 0000 0400 01 0400 1234 1 0 0
04 4543 0000 0400 01 0400 1234 1 1 0
04 4741 0000 FC00 01 FC00 BEEF 1 0 0
04 4741 0000 FC00 01 FC00 BEEF 1 0 0
04 4741 0000 FC00 01 FC00 BEEF 1 0 0
04 4741 0000 FC00 01 FC00 BEEF 1 1 0
// logic: and or xor xori lsh right andi, cmp keeps r7
05 0512 0000 0000 01 1234 0400 0 1 0
05 0521 0000 FC00 02 0000 FC00 0 1 0
05 0531 0000 0000 01 FC00 FC00 0 1 0
05 3411 0000 BEFE 02 BEEF FC00 0 1 0
05 D8FC 0000 FFFC 01 0000 0000 0 1 0
05 0388 0000 0040 01 0400 FFFC 0 1 0
05 130F 0000 0000 00 0040 0000 0 1 0
05 07B6 0000 ACBB 02 BEEF 1234 0 1 0
05 09D7 0000 BEEF 08 0000 BEEF 0 1 0
